/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam int DBITS     = 32;
    localparam int REGNOBITS = 4;
    localparam int REGWORDS  = 1 << REGNOBITS;
    localparam int IMMBITS   = 16;
    localparam int OP1BITS   = 6;
    localparam int OP2BITS   = 8;

    typedef logic [DBITS-1:0]     word_t;
    typedef logic [REGNOBITS-1:0] reg_idx_t;
    typedef logic [OP1BITS-1:0]   op1_t;
    typedef logic [OP2BITS-1:0]   op2_t;
    typedef logic [1:0]           wb_src_t;

    localparam word_t START_PC  = 32'h100;
    localparam word_t INST_SIZE = 32'd4;

    // Primary opcodes
    localparam op1_t OP1_ALUR = 6'b000000;
    localparam op1_t OP1_BEQ  = 6'b001000;
    localparam op1_t OP1_BLT  = 6'b001001;
    localparam op1_t OP1_BLE  = 6'b001010;
    localparam op1_t OP1_BNE  = 6'b001011;
    localparam op1_t OP1_JAL  = 6'b001100;
    localparam op1_t OP1_LW   = 6'b010010;
    localparam op1_t OP1_SW   = 6'b011010;
    localparam op1_t OP1_ADDI = 6'b100000;
    localparam op1_t OP1_ANDI = 6'b100100;
    localparam op1_t OP1_ORI  = 6'b100101;
    localparam op1_t OP1_XORI = 6'b100110;

    // Secondary opcodes, ALUR only
    localparam op2_t OP2_EQ   = 8'b00001000;
    localparam op2_t OP2_LT   = 8'b00001001;
    localparam op2_t OP2_LE   = 8'b00001010;
    localparam op2_t OP2_NE   = 8'b00001011;
    localparam op2_t OP2_ADD  = 8'b00100000;
    localparam op2_t OP2_AND  = 8'b00100100;
    localparam op2_t OP2_OR   = 8'b00100101;
    localparam op2_t OP2_XOR  = 8'b00100110;
    localparam op2_t OP2_SUB  = 8'b00101000;
    localparam op2_t OP2_NAND = 8'b00101100;
    localparam op2_t OP2_NOR  = 8'b00101101;
    localparam op2_t OP2_NXOR = 8'b00101110;
    localparam op2_t OP2_RSHF = 8'b00110000;
    localparam op2_t OP2_LSHF = 8'b00110001;

    localparam wb_src_t WB_PC  = 2'b00;  // Link value
    localparam wb_src_t WB_MEM = 2'b01;  // Load data
    localparam wb_src_t WB_ALU = 2'b10;

    typedef struct packed {
        op1_t       op1;
        op2_t       op2;
        logic [5:0] rsvd;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
    } alu_r_fmt_t;

    typedef struct packed {
        op1_t               op1;
        logic [1:0]         rsvd;
        logic [IMMBITS-1:0] imm;
        reg_idx_t           rs;
        reg_idx_t           rt;
    } imm_fmt_t;

    // Same word, two field layouts
    typedef union packed {
        alu_r_fmt_t r;
        imm_fmt_t   i;
    } instr_t;

    typedef struct packed {
        logic     valid;
        op1_t     op1;
        op2_t     op2;
        word_t    link_pc;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;      // Sign extended
        reg_idx_t dst;
        logic     reg_we;
        logic     mem_we;
        logic     mem_re;
        wb_src_t  wb_src;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    link_pc;
        word_t    alu;
        word_t    store_data;
        reg_idx_t dst;
        logic     reg_we;
        logic     mem_we;
        logic     mem_re;
        wb_src_t  wb_src;
    } ex_mem_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } reg_wr_t;

endpackage

/* rtl/fetch_stage.sv */
module fetch_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            mem_busy,
    input  logic            hazard_stall,
    input  logic            redirect,
    input  cpu_pkg::word_t  redirect_pc,
    output cpu_pkg::word_t  imem_addr,
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::instr_t fe_instr,
    output cpu_pkg::word_t  fe_pc,
    output logic            fe_valid
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_plus;
    logic           advance;

    assign imem_addr = pc;
    assign pc_plus   = pc + cpu_pkg::INST_SIZE;
    assign advance   = !mem_busy && !hazard_stall && !redirect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= cpu_pkg::START_PC;
            fe_valid <= 1'b0;
        end else if (!mem_busy && redirect) begin
            pc       <= redirect_pc;  // Taken branch or JAL
            fe_valid <= 1'b0;
        end else if (advance) begin
            pc       <= pc_plus;
            fe_valid <= 1'b1;
        end
    end

    // Instruction word and link value
    always_ff @(posedge clk) begin
        if (advance) begin
            fe_instr <= instr;
            fe_pc    <= pc_plus;
        end
    end

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::instr_t   fe_instr,
    input  cpu_pkg::word_t    fe_pc,
    input  logic              fe_valid,
    output cpu_pkg::reg_idx_t rs_idx,
    output cpu_pkg::reg_idx_t rt_idx,
    input  cpu_pkg::word_t    rs_val,
    input  cpu_pkg::word_t    rt_val,
    output cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::ex_mem_t  ex_mem,
    input  logic              redirect,
    input  logic              mem_busy,
    output logic              hazard_stall
);

    cpu_pkg::id_ex_t dec;
    logic            is_branch;
    logic            uses_rt;
    logic            rs_hit;
    logic            rt_hit;

    // True if an older instruction will still write idx
    function automatic logic pending_write(
        input cpu_pkg::reg_idx_t idx,
        input cpu_pkg::id_ex_t   ex,
        input cpu_pkg::ex_mem_t  mem
    );
        return (idx != '0) &&
               ((ex.valid && ex.reg_we && ex.dst == idx) ||
                (mem.valid && mem.reg_we && mem.dst == idx));
    endfunction

    assign rs_idx = fe_instr.r.rs;
    assign rt_idx = fe_instr.r.rt;

    assign is_branch = (fe_instr.r.op1 == cpu_pkg::OP1_BEQ) ||
                       (fe_instr.r.op1 == cpu_pkg::OP1_BLT) ||
                       (fe_instr.r.op1 == cpu_pkg::OP1_BLE) ||
                       (fe_instr.r.op1 == cpu_pkg::OP1_BNE);
    assign uses_rt   = is_branch || (fe_instr.r.op1 == cpu_pkg::OP1_ALUR) ||
                       (fe_instr.r.op1 == cpu_pkg::OP1_SW);

    assign rs_hit = pending_write(rs_idx, id_ex, ex_mem);
    assign rt_hit = uses_rt && pending_write(rt_idx, id_ex, ex_mem);
    assign hazard_stall = fe_valid && (rs_hit || rt_hit);

    always_comb begin
        dec         = '0;
        dec.valid   = fe_valid;
        dec.op1     = fe_instr.r.op1;
        dec.op2     = fe_instr.r.op2;
        dec.link_pc = fe_pc;
        dec.rs_val  = rs_val;
        dec.rt_val  = rt_val;
        dec.imm     = {{(cpu_pkg::DBITS - cpu_pkg::IMMBITS){fe_instr.i.imm[cpu_pkg::IMMBITS-1]}},
                       fe_instr.i.imm};
        dec.dst     = fe_instr.i.rt;  // rt unless ALUR
        case (fe_instr.r.op1)
            cpu_pkg::OP1_ALUR: begin
                dec.dst    = fe_instr.r.rd;
                dec.reg_we = 1'b1;
                dec.wb_src = cpu_pkg::WB_ALU;
            end
            cpu_pkg::OP1_JAL: begin
                dec.reg_we = 1'b1;
                dec.wb_src = cpu_pkg::WB_PC;
            end
            cpu_pkg::OP1_LW: begin
                dec.mem_re = 1'b1;
                dec.reg_we = 1'b1;
                dec.wb_src = cpu_pkg::WB_MEM;
            end
            cpu_pkg::OP1_SW: dec.mem_we = 1'b1;
            cpu_pkg::OP1_ADDI, cpu_pkg::OP1_ANDI, cpu_pkg::OP1_ORI, cpu_pkg::OP1_XORI: begin
                dec.reg_we = 1'b1;
                dec.wb_src = cpu_pkg::WB_ALU;
            end
            default: ;  // Branches and unknown opcodes write nothing
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (!mem_busy) begin
            if (hazard_stall || redirect)
                id_ex <= '0;  // Bubble
            else
                id_ex <= dec;
        end
    end

endmodule

/* rtl/register_file.sv */
module register_file (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_idx_t rs_idx,
    input  cpu_pkg::reg_idx_t rt_idx,
    output cpu_pkg::word_t    rs_val,
    output cpu_pkg::word_t    rt_val,
    input  cpu_pkg::reg_wr_t  reg_wr
);

    cpu_pkg::word_t regs [cpu_pkg::REGWORDS];
    logic           wr_ok;

    // r0 stays zero, in line with the hazard check ignoring it
    assign wr_ok = reg_wr.en && (reg_wr.idx != '0);

    // Write in the same cycle wins over the stored word
    function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_idx_t idx);
        if (wr_ok && reg_wr.idx == idx)
            return reg_wr.data;
        return regs[idx];
    endfunction

    always_comb begin
        rs_val = read_port(rs_idx);
        rt_val = read_port(rt_idx);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::REGWORDS; i++)
                regs[i] <= '0;
        end else if (wr_ok) begin
            regs[reg_wr.idx] <= reg_wr.data;
        end
    end

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::id_ex_t  id_ex,
    input  logic             mem_busy,
    output logic             redirect,
    output cpu_pkg::word_t   redirect_pc,
    output cpu_pkg::ex_mem_t ex_mem
);

    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t alu_out;
    cpu_pkg::word_t offset;
    logic           is_jal;
    logic           br_taken;

    assign a      = id_ex.rs_val;
    assign b      = (id_ex.op1 == cpu_pkg::OP1_ALUR) ? id_ex.rt_val : id_ex.imm;
    assign offset = id_ex.imm << 2;  // Word offset
    assign is_jal = (id_ex.op1 == cpu_pkg::OP1_JAL);

    always_comb begin
        alu_out = '0;
        case (id_ex.op1)
            cpu_pkg::OP1_ALUR: begin
                case (id_ex.op2)
                    cpu_pkg::OP2_EQ:   alu_out = {31'b0, a == b};
                    cpu_pkg::OP2_LT:   alu_out = {31'b0, $signed(a) < $signed(b)};
                    cpu_pkg::OP2_LE:   alu_out = {31'b0, $signed(a) <= $signed(b)};
                    cpu_pkg::OP2_NE:   alu_out = {31'b0, a != b};
                    cpu_pkg::OP2_ADD:  alu_out = a + b;
                    cpu_pkg::OP2_AND:  alu_out = a & b;
                    cpu_pkg::OP2_OR:   alu_out = a | b;
                    cpu_pkg::OP2_XOR:  alu_out = a ^ b;
                    cpu_pkg::OP2_SUB:  alu_out = a - b;
                    cpu_pkg::OP2_NAND: alu_out = ~(a & b);
                    cpu_pkg::OP2_NOR:  alu_out = ~(a | b);
                    cpu_pkg::OP2_NXOR: alu_out = ~(a ^ b);
                    cpu_pkg::OP2_RSHF: alu_out = $signed(a) >>> b;  // Arithmetic
                    cpu_pkg::OP2_LSHF: alu_out = a << b;
                    default:           alu_out = '0;
                endcase
            end
            cpu_pkg::OP1_ADDI, cpu_pkg::OP1_LW, cpu_pkg::OP1_SW: alu_out = a + b;
            cpu_pkg::OP1_ANDI: alu_out = a & b;
            cpu_pkg::OP1_ORI:  alu_out = a | b;
            cpu_pkg::OP1_XORI: alu_out = a ^ b;
            default:           alu_out = '0;
        endcase
    end

    // Signed compare of rs and rt
    always_comb begin
        case (id_ex.op1)
            cpu_pkg::OP1_BEQ: br_taken = (id_ex.rs_val == id_ex.rt_val);
            cpu_pkg::OP1_BLT: br_taken = ($signed(id_ex.rs_val) < $signed(id_ex.rt_val));
            cpu_pkg::OP1_BLE: br_taken = ($signed(id_ex.rs_val) <= $signed(id_ex.rt_val));
            cpu_pkg::OP1_BNE: br_taken = (id_ex.rs_val != id_ex.rt_val);
            default:          br_taken = 1'b0;
        endcase
    end

    assign redirect    = id_ex.valid && (br_taken || is_jal);
    assign redirect_pc = is_jal ? a + offset : id_ex.link_pc + offset;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (!mem_busy) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.link_pc    <= id_ex.link_pc;
            ex_mem.alu        <= alu_out;
            ex_mem.store_data <= id_ex.rt_val;
            ex_mem.dst        <= id_ex.dst;
            ex_mem.reg_we     <= id_ex.reg_we;
            ex_mem.mem_we     <= id_ex.mem_we;
            ex_mem.mem_re     <= id_ex.mem_re;
            ex_mem.wb_src     <= id_ex.wb_src;
        end
    end

endmodule

/* rtl/mem_wb_stage.sv */
module mem_wb_stage (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::wb_req_t wb_out,
    input  cpu_pkg::wb_rsp_t wb_in,
    output logic             mem_busy,
    output cpu_pkg::reg_wr_t reg_wr
);

    logic           mem_op;
    logic           ack_now;
    logic           launch;
    logic           req_live;  // cyc and stb together
    logic           req_we;
    cpu_pkg::word_t req_adr;
    cpu_pkg::word_t req_dat;

    assign mem_op   = ex_mem.valid && (ex_mem.mem_we || ex_mem.mem_re);
    assign ack_now  = req_live && wb_in.ack;
    assign launch   = mem_op && !req_live;
    assign mem_busy = mem_op && !ack_now;

    assign wb_out = '{cyc: req_live, stb: req_live, we: req_we, adr: req_adr, dat_w: req_dat};

    // Request goes out the cycle after the entry arrives, drops after ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_live <= 1'b0;
            req_we   <= 1'b0;
        end else if (ack_now) begin
            req_live <= 1'b0;
            req_we   <= 1'b0;
        end else if (launch) begin
            req_live <= 1'b1;
            req_we   <= ex_mem.mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            req_adr <= ex_mem.alu;
            req_dat <= ex_mem.store_data;
        end
    end

    // Loads write in the ack cycle, everything else on arrival
    always_comb begin
        reg_wr.en   = ex_mem.valid && ex_mem.reg_we && (!mem_op || ack_now);
        reg_wr.idx  = ex_mem.dst;
        reg_wr.data = ex_mem.alu;
        case (ex_mem.wb_src)
            cpu_pkg::WB_PC:  reg_wr.data = ex_mem.link_pc;
            cpu_pkg::WB_MEM: reg_wr.data = wb_in.dat_r;
            default:         ;
        endcase
    end

endmodule

/* rtl/cpu_top.sv */
module cpu_top (
    input  logic             clk,
    input  logic             reset,
    output cpu_pkg::word_t   imem_addr,
    input  cpu_pkg::instr_t  instr,
    output cpu_pkg::wb_req_t wb_out,
    input  cpu_pkg::wb_rsp_t wb_in
);

    cpu_pkg::instr_t   fe_instr;
    cpu_pkg::word_t    fe_pc;
    logic              fe_valid;
    cpu_pkg::reg_idx_t rs_idx;
    cpu_pkg::reg_idx_t rt_idx;
    cpu_pkg::word_t    rs_val;
    cpu_pkg::word_t    rt_val;
    cpu_pkg::id_ex_t   id_ex;
    cpu_pkg::ex_mem_t  ex_mem;
    cpu_pkg::reg_wr_t  reg_wr;
    logic              redirect;
    cpu_pkg::word_t    redirect_pc;
    logic              mem_busy;
    logic              hazard_stall;

    fetch_stage u_fetch (
        .clk          (clk),
        .reset        (reset),
        .mem_busy     (mem_busy),
        .hazard_stall (hazard_stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .imem_addr    (imem_addr),
        .instr        (instr),
        .fe_instr     (fe_instr),
        .fe_pc        (fe_pc),
        .fe_valid     (fe_valid)
    );

    decode_stage u_decode (
        .clk          (clk),
        .reset        (reset),
        .fe_instr     (fe_instr),
        .fe_pc        (fe_pc),
        .fe_valid     (fe_valid),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .redirect     (redirect),
        .mem_busy     (mem_busy),
        .hazard_stall (hazard_stall)
    );

    register_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .reg_wr (reg_wr)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .mem_busy    (mem_busy),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    mem_wb_stage u_mem_wb (
        .clk      (clk),
        .reset    (reset),
        .ex_mem   (ex_mem),
        .wb_out   (wb_out),
        .wb_in    (wb_in),
        .mem_busy (mem_busy),
        .reg_wr   (reg_wr)
    );

endmodule

/* sim/cpu_checker.sv */
module cpu_checker (
    input logic             clk,
    input logic             reset,
    input cpu_pkg::word_t   imem_addr,
    input cpu_pkg::wb_req_t wb_out,
    input cpu_pkg::wb_rsp_t wb_in
);

    int fail_count = 0;  // Read by the testbench at the end of the run

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_out.stb |-> wb_out.cyc)
        else begin
            $error("Wishbone stb high while cyc is low");
            fail_count++;
        end

    // Master must hold the request until the slave acks
    req_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_out.stb && !wb_in.ack) |=> $stable(wb_out))
        else begin
            $error("Wishbone request changed before ack");
            fail_count++;
        end

    cyc_low_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !wb_out.cyc)
        else begin
            $error("Wishbone cyc high in the first cycle after reset");
            fail_count++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("Fetch address not word aligned");
            fail_count++;
        end

endmodule

bind cpu_top cpu_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .wb_out    (wb_out),
    .wb_in     (wb_in)
);

/* sim/tb_cpu.sv */
module tb_cpu;

    localparam int NCASES   = 32;
    localparam int PROG_LEN = 8;
    localparam int TIMEOUT  = 200;
    localparam int NWAITS   = 256;

    logic               clk   = 1'b0;
    logic               reset = 1'b1;
    cpu_pkg::word_t     imem_addr;
    cpu_pkg::instr_t    instr;
    cpu_pkg::wb_req_t   wb_out;
    cpu_pkg::wb_rsp_t   wb_in = '0;

    // Case table
    string              case_name [NCASES];
    cpu_pkg::instr_t    case_prog [NCASES][PROG_LEN];
    cpu_pkg::word_t     case_addr [NCASES];
    cpu_pkg::word_t     case_data [NCASES];
    int                 n_cases = 0;
    int                 n_words = 0;

    cpu_pkg::instr_t    cur_prog [PROG_LEN];
    int unsigned        fetch_idx;

    // Wishbone slave state
    cpu_pkg::word_t     mem [cpu_pkg::word_t];
    int                 wait_tbl [NWAITS];
    int                 wait_pos = 0;
    int                 wait_cnt = 0;

    cpu_top DUT (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .instr     (instr),
        .wb_out    (wb_out),
        .wb_in     (wb_in)
    );

    always #4 clk = ~clk;

    function automatic cpu_pkg::instr_t enc_i(input cpu_pkg::op1_t op1,
                                              input cpu_pkg::reg_idx_t rs,
                                              input cpu_pkg::reg_idx_t rt,
                                              input logic [15:0] imm);
        cpu_pkg::instr_t w;
        w       = '0;
        w.i.op1 = op1;
        w.i.imm = imm;
        w.i.rs  = rs;
        w.i.rt  = rt;
        return w;
    endfunction

    function automatic cpu_pkg::instr_t enc_r(input cpu_pkg::op2_t op2,
                                              input cpu_pkg::reg_idx_t rd,
                                              input cpu_pkg::reg_idx_t rs,
                                              input cpu_pkg::reg_idx_t rt);
        cpu_pkg::instr_t w;
        w       = '0;
        w.r.op1 = cpu_pkg::OP1_ALUR;
        w.r.op2 = op2;
        w.r.rd  = rd;
        w.r.rs  = rs;
        w.r.rt  = rt;
        return w;
    endfunction

    // Unwritten words read back as a pattern of their address
    function automatic cpu_pkg::word_t read_mem(input cpu_pkg::word_t adr);
        if (mem.exists(adr))
            return mem[adr];
        return adr ^ 32'h5A5A_5A5A;
    endfunction

    always_comb begin
        fetch_idx = (imem_addr - cpu_pkg::START_PC) >> 2;
        if (fetch_idx < PROG_LEN)
            instr = cur_prog[fetch_idx];
        else
            instr = enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd0, 16'h0);  // No-op
    end

    always @(posedge clk) begin
        if (reset) begin
            wb_in <= '0;
        end else if (wb_out.stb && !wb_in.ack) begin
            if (wait_cnt == 0) begin
                wb_in.ack   <= 1'b1;
                wb_in.dat_r <= read_mem(wb_out.adr);
                if (wb_out.we)
                    mem[wb_out.adr] = wb_out.dat_w;
                wait_cnt <= wait_tbl[wait_pos % NWAITS];
                wait_pos <= wait_pos + 1;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else begin
            wb_in.ack <= 1'b0;
        end
    end

    task automatic new_case(input string name, input cpu_pkg::word_t addr,
                            input cpu_pkg::word_t data);
        case_name[n_cases] = name;
        case_addr[n_cases] = addr;
        case_data[n_cases] = data;
        for (int i = 0; i < PROG_LEN; i++)
            case_prog[n_cases][i] = enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd0, 16'h0);
        n_cases++;
        n_words = 0;
    endtask

    task automatic put(input cpu_pkg::instr_t w);
        case_prog[n_cases-1][n_words] = w;
        n_words++;
    endtask

    // r1 = a, r2 = b, r3 = r1 op r2, store r3 at 0x800
    task automatic alu_case(input string name, input cpu_pkg::op2_t op2,
                            input logic [15:0] a, input logic [15:0] b,
                            input cpu_pkg::word_t expected);
        new_case(name, 32'h800, expected);
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, a));
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, b));
        put(enc_r(op2, 4'd3, 4'd1, 4'd2));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd3, 16'h0800));
    endtask

    task automatic imm_case(input string name, input cpu_pkg::op1_t op1,
                            input logic [15:0] a, input logic [15:0] imm,
                            input cpu_pkg::word_t expected);
        new_case(name, 32'h800, expected);
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, a));
        put(enc_i(op1, 4'd1, 4'd2, imm));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd2, 16'h0800));
    endtask

    // Branch at 0x108 with offset 2 lands on the pair that stores to 0x804
    task automatic branch_case(input string name, input cpu_pkg::op1_t op1,
                               input logic [15:0] a, input logic [15:0] b,
                               input logic taken);
        new_case(name, taken ? 32'h804 : 32'h800, taken ? 32'h22 : 32'h11);
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, a));
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd2, b));
        put(enc_i(op1, 4'd1, 4'd2, 16'd2));
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd3, 16'h11));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd3, 16'h0800));
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd3, 16'h22));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd3, 16'h0804));
    endtask

    task automatic build_table();
        alu_case("eq",   cpu_pkg::OP2_EQ,   16'd5,    16'd5,    32'd1);
        alu_case("lt",   cpu_pkg::OP2_LT,   16'hFFFD, 16'd2,    32'd1);
        alu_case("le",   cpu_pkg::OP2_LE,   16'd4,    16'd4,    32'd1);
        alu_case("ne",   cpu_pkg::OP2_NE,   16'd4,    16'd4,    32'd0);
        alu_case("add",  cpu_pkg::OP2_ADD,  16'hFFFF, 16'd1,    32'd0);  // Wraps
        alu_case("and",  cpu_pkg::OP2_AND,  16'h0FF0, 16'h00FF, 32'h0000_00F0);
        alu_case("or",   cpu_pkg::OP2_OR,   16'h0F00, 16'h00F0, 32'h0000_0FF0);
        alu_case("xor",  cpu_pkg::OP2_XOR,  16'h0FF0, 16'h00FF, 32'h0000_0F0F);
        alu_case("sub",  cpu_pkg::OP2_SUB,  16'd5,    16'd9,    32'hFFFF_FFFC);
        alu_case("nand", cpu_pkg::OP2_NAND, 16'h0FF0, 16'h00FF, 32'hFFFF_FF0F);
        alu_case("nor",  cpu_pkg::OP2_NOR,  16'h0F00, 16'h00F0, 32'hFFFF_F00F);
        alu_case("nxor", cpu_pkg::OP2_NXOR, 16'h0FF0, 16'h00FF, 32'hFFFF_F0F0);
        alu_case("rshf", cpu_pkg::OP2_RSHF, 16'hFFF0, 16'd2,    32'hFFFF_FFFC);
        alu_case("lshf", cpu_pkg::OP2_LSHF, 16'd3,    16'd4,    32'h0000_0030);
        imm_case("addi_neg",  cpu_pkg::OP1_ADDI, 16'd10,   16'hFFFF, 32'd9);
        imm_case("andi_sext", cpu_pkg::OP1_ANDI, 16'h8765, 16'hFFFF, 32'hFFFF_8765);
        imm_case("ori_sext",  cpu_pkg::OP1_ORI,  16'h0012, 16'h8000, 32'hFFFF_8012);
        imm_case("xori_sext", cpu_pkg::OP1_XORI, 16'h00FF, 16'hFFFF, 32'hFFFF_FF00);
        branch_case("beq_taken",  cpu_pkg::OP1_BEQ, 16'd3,    16'd3,    1'b1);
        branch_case("beq_fall",   cpu_pkg::OP1_BEQ, 16'd3,    16'd4,    1'b0);
        branch_case("blt_signed", cpu_pkg::OP1_BLT, 16'hFFFF, 16'd1,    1'b1);
        branch_case("blt_fall",   cpu_pkg::OP1_BLT, 16'd1,    16'hFFFF, 1'b0);
        branch_case("ble_equal",  cpu_pkg::OP1_BLE, 16'hFFFE, 16'hFFFE, 1'b1);
        branch_case("ble_fall",   cpu_pkg::OP1_BLE, 16'd2,    16'hFFFE, 1'b0);
        branch_case("bne_taken",  cpu_pkg::OP1_BNE, 16'd3,    16'd4,    1'b1);
        branch_case("bne_fall",   cpu_pkg::OP1_BNE, 16'd3,    16'd3,    1'b0);
        // (5 + 6) * 2, first back to back and then spaced by no-ops
        new_case("chain_tight", 32'h800, 32'd22);
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'd5));
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd1, 4'd1, 16'd6));
        put(enc_r(cpu_pkg::OP2_ADD, 4'd2, 4'd1, 4'd1));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd2, 16'h0800));
        new_case("chain_spaced", 32'h800, 32'd22);
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'd5));
        n_words += 2;
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd1, 4'd1, 16'd6));
        n_words += 2;
        put(enc_r(cpu_pkg::OP2_ADD, 4'd2, 4'd1, 4'd1));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd2, 16'h0800));
        // JAL at 0x104 links 0x108 into r2 and jumps to 0x100 + 4 * 5
        new_case("jal", 32'h804, 32'h108);
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'h0100));
        put(enc_i(cpu_pkg::OP1_JAL, 4'd1, 4'd2, 16'd5));
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd3, 16'd1));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd3, 16'h0800));
        n_words++;
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd2, 16'h0804));
        new_case("store_load", 32'h800, 32'h0000_7ABC);
        put(enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd1, 16'h7ABC));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd1, 16'h0400));
        put(enc_i(cpu_pkg::OP1_LW, 4'd0, 4'd2, 16'h0400));
        put(enc_i(cpu_pkg::OP1_SW, 4'd0, 4'd2, 16'h0800));
    endtask

    task automatic check_addr(input string name, input cpu_pkg::word_t expected,
                              input cpu_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s store address: expected 0x%08h, actual 0x%08h",
                     name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "store address mismatch");
        end
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t expected,
                              input cpu_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s store data: expected 0x%08h, actual 0x%08h",
                     name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "store data mismatch");
        end
    endtask

    // First store at 0x800 or above ends the case
    task automatic wait_store(input int k, output cpu_pkg::word_t adr,
                              output cpu_pkg::word_t dat);
        logic found;
        found = 1'b0;
        for (int cycles = 0; cycles < TIMEOUT && !found; cycles++) begin
            @(posedge clk);
            if (wb_out.cyc && wb_out.stb && wb_out.we && wb_out.adr >= 32'h800) begin
                found = 1'b1;
                adr   = wb_out.adr;
                dat   = wb_out.dat_w;
            end
        end
        if (!found) begin
            $display("Case %s never stored to 0x800 or above within %0d cycles",
                     case_name[k], TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1, "store timeout");
        end
    endtask

    task automatic run_case(input int k);
        cpu_pkg::word_t adr;
        cpu_pkg::word_t dat;
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < PROG_LEN; i++)
            cur_prog[i] = case_prog[k][i];
        mem.delete();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait_store(k, adr, dat);
        check_addr(case_name[k], case_addr[k], adr);
        check_word(case_name[k], case_data[k], dat);
    endtask

    initial begin
        void'($urandom(47));
        for (int i = 0; i < NWAITS; i++)
            wait_tbl[i] = $urandom_range(3, 0);
        for (int i = 0; i < PROG_LEN; i++)
            cur_prog[i] = enc_i(cpu_pkg::OP1_ADDI, 4'd0, 4'd0, 16'h0);
        build_table();
        for (int k = 0; k < n_cases; k++)
            run_case(k);
        if (DUT.u_checker.fail_count != 0) begin
            $display("Bus or fetch port assertions failed %0d times",
                     DUT.u_checker.fail_count);
            $display("Simulation FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* compile.f */
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu_top.sv
sim/cpu_checker.sv
sim/tb_cpu.sv
